//--- dv/pll_pair_tests.txt
# kind sw settle window mask gain ref a_clk a_div8 b_clk b_div8 tol_div tol_clk
# kind 0 holds reset for window cycles, its five count columns are then output levels
# mask bit 0 checks the gains, bits 1..5 check ref, a_clk, a_div8, b_clk, b_div8
# reset with word 19 on the switches and load high, gains show 8 and 9
0 1013 0 10 3f 89 0 0 0 0 0 0 0
# gain capture with load low and loops open
1 0a53 1 100 01 a3 0 0 0 0 0 0 0
1 0f00 1 100 01 f0 0 0 0 0 0 0 0
1 0000 1 100 01 00 0 0 0 0 0 0 0
# load high holds the gains, reference words 256, 1000, 19
# loops open, a runs at 154 and b at 153
1 1100 4 4096 3f 00 256 154 19 153 19 1 1
1 13e8 4 4096 3f 00 1000 154 19 153 19 1 1
1 1013 4 4096 3f 00 19 154 19 153 19 1 1
# gains back to 8 and 9, still open loop
1 0809 1 100 01 89 0 0 0 0 0 0 0
# loops closed on word 19, late window after settling
1 8809 20000 16384 2f 89 76 608 76 0 76 2 16
# retune to word 21 with the loops closed, gains held by the load level
1 9015 20000 16384 2f 89 84 672 84 0 84 2 16

//--- pll_pair_top.f
source/pll_num_pkg.sv
source/pll_cfg_pkg.sv
source/pll_config_regs.sv
source/phase_accum_osc.sv
source/phase_detector.sv
source/pi_loop_filter.sv
source/adpll_core.sv
source/pll_pair_top.sv
dv/pll_pair_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the pll pair testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f pll_pair_top.f --top-module pll_pair_tb -o sim_pll_pair

sim_out=$(./obj_dir/sim_pll_pair || true)
echo "$sim_out"

if grep -q "Simulation finished: PASS" <<< "$sim_out"
then
    exit 0
else
    echo "run_sim: simulation did not pass"
    exit 1
fi

//--- dv/pll_pair_tb.sv
module pll_pair_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import pll_cfg_pkg::*;

    localparam int    CLK_HALF       = 5;                         // 10 ns period
    localparam int    TIMEOUT_MARGIN = 2000;                      // slack on top of all windows
    localparam int    N_OUT          = 5;                         // clock outputs watched
    localparam string TEST_FILE      = "dv/pll_pair_tests.txt";

    typedef struct packed {
        int               kind;       // 0 reset line, 1 window line
        logic [15:0]      sw;         // switch word
        int               settle;     // cycles before the window
        int               window;     // counting cycles, or reset length
        logic [7:0]       mask;       // bit 0 gains, bits 1..5 outputs
        logic [7:0]       gain;       // {kp, ki}
        logic [4:0][15:0] exp_val;    // ref, a_clk, a_div8, b_clk, b_div8
        int               tol_div;    // ref and div8 columns
        int               tol_clk;    // oscillator columns
    } test_t;

    logic      clk258_x;
    logic      rst_n_i;
    logic      [15:0] switches_i;
    logic      ref_clk_o;
    logic      pll_a_clk_o;
    logic      pll_a_div8_o;
    logic      pll_b_clk_o;
    logic      pll_b_div8_o;
    pll_gain_t gain_disp_o;

    test_t     tests[$];              // whole file, read before the clock starts
    int        cycle_cnt   = 0;
    int        cycle_limit = 0;       // 0 until the file is read

    pll_pair_top pll_pair_top_i (
        .clk258_x     (clk258_x),
        .rst_n_i      (rst_n_i),
        .switches_i   (switches_i),
        .ref_clk_o    (ref_clk_o),
        .pll_a_clk_o  (pll_a_clk_o),
        .pll_a_div8_o (pll_a_div8_o),
        .pll_b_clk_o  (pll_b_clk_o),
        .pll_b_div8_o (pll_b_div8_o),
        .gain_disp_o  (gain_disp_o)
    );

    always #CLK_HALF clk258_x = ~clk258_x;

    // run length bound from the file
    always @(posedge clk258_x)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
        begin
            $display("timeout: the tests ran past %0d clock cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string what, input int actual, input int expected,
                               input int tol);
        int diff;
        diff = actual - expected;
        if (diff < 0)
            diff = -diff;                                // distance only
        if (diff > tol)
        begin
            $display("error at %0t ns: %s is %0d, expected %0d within %0d",
                     $time, what, actual, expected, tol);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic string output_name(input int idx);
        case (idx)
            0:       return "ref_clk_o";
            1:       return "pll_a_clk_o";
            2:       return "pll_a_div8_o";
            3:       return "pll_b_clk_o";
            default: return "pll_b_div8_o";
        endcase
    endfunction

    // bit order matches exp_val
    function automatic logic [4:0] sample_outputs();
        return {pll_b_div8_o, pll_b_clk_o, pll_a_div8_o, pll_a_clk_o, ref_clk_o};
    endfunction

    task automatic read_tests();
        int          fd;
        int          n;
        int          idx;
        int          sum;
        string       line;
        test_t       t;
        int          kind;
        int          settle;
        int          window;
        int          tol_div;
        int          tol_clk;
        int          e [N_OUT];
        logic [15:0] sw;
        logic [7:0]  mask;
        logic [7:0]  gain;
        sum = 0;
        fd  = $fopen(TEST_FILE, "r");
        if (fd == 0)
        begin
            $display("could not open the test file %s", TEST_FILE);
            $display("Simulation finished: FAIL");
            $fatal(1, "no test file");
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;                                // blank or comment
            n = $sscanf(line, "%d %h %d %d %h %h %d %d %d %d %d %d %d", kind, sw, settle,
                        window, mask, gain, e[0], e[1], e[2], e[3], e[4], tol_div, tol_clk);
            if (n != 13)
            begin
                $display("the test file has a line with %0d fields instead of 13", n);
                $display("Simulation finished: FAIL");
                $fatal(1, "bad test line");
            end
            t.kind    = kind;
            t.sw      = sw;
            t.settle  = settle;
            t.window  = window;
            t.mask    = mask;
            t.gain    = gain;
            t.tol_div = tol_div;
            t.tol_clk = tol_clk;
            for (idx = 0; idx < N_OUT; idx++)
                t.exp_val[idx] = 16'(e[idx]);
            tests.push_back(t);
            sum += settle + window + 4;                  // drive, release and check cycles
        end
        $fclose(fd);
        cycle_limit = sum + TIMEOUT_MARGIN;
    endtask

    task automatic check_levels(input test_t t);
        logic [4:0] lvl;
        int         idx;
        lvl = sample_outputs();
        for (idx = 0; idx < N_OUT; idx++)
            if (t.mask[idx+1])
                check_value(output_name(idx), int'(lvl[idx]), int'(t.exp_val[idx]), 0);
    endtask

    // hold reset, outputs must stay at the listed levels during and after it
    task automatic run_reset(input test_t t);
        @(posedge clk258_x);
        rst_n_i    <= 1'b0;
        switches_i <= t.sw;
        repeat (t.window)
        begin
            @(negedge clk258_x);
            check_levels(t);
        end
        @(posedge clk258_x);
        rst_n_i <= 1'b1;
        repeat (t.settle) @(posedge clk258_x);
        @(negedge clk258_x);
        check_levels(t);                                 // first cycle out of reset
        if (t.mask[0])
            check_value("gain_disp_o", int'(gain_disp_o), int'(t.gain), 0);
    endtask

    task automatic run_window(input test_t t);
        logic [4:0] prev;
        logic [4:0] now;
        int         cnt [N_OUT];
        int         idx;
        int         tol;
        @(posedge clk258_x);
        switches_i <= t.sw;
        repeat (t.settle) @(posedge clk258_x);
        @(negedge clk258_x);                             // mid cycle, outputs settled
        if (t.mask[0])
            check_value("gain_disp_o", int'(gain_disp_o), int'(t.gain), 0);
        prev = sample_outputs();
        for (idx = 0; idx < N_OUT; idx++)
            cnt[idx] = 0;
        repeat (t.window)
        begin
            @(negedge clk258_x);
            now = sample_outputs();
            for (idx = 0; idx < N_OUT; idx++)
                if (now[idx] && !prev[idx])
                    cnt[idx]++;                          // rising edge seen
            prev = now;
        end
        if (t.mask[0])
            check_value("gain_disp_o", int'(gain_disp_o), int'(t.gain), 0);   // still held
        for (idx = 0; idx < N_OUT; idx++)
        begin
            tol = (idx == 1 || idx == 3) ? t.tol_clk : t.tol_div;
            if (t.mask[idx+1])
                check_value(output_name(idx), cnt[idx], int'(t.exp_val[idx]), tol);
        end
    endtask

    initial
    begin
        clk258_x   = 1'b0;
        rst_n_i    = 1'b0;                               // in reset from time zero
        switches_i = '0;
        read_tests();
        foreach (tests[n])
        begin
            if (tests[n].kind == 0)
                run_reset(tests[n]);
            else
                run_window(tests[n]);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- source/pll_pair_top.sv
module pll_pair_top (
    input  logic                              clk258_x,
    input  logic                              rst_n_i,
    input  logic [pll_cfg_pkg::SW_WIDTH-1:0]  switches_i,    // 15 enable, 12 load
    output logic                              ref_clk_o,     // reference nco
    output logic                              pll_a_clk_o,
    output logic                              pll_a_div8_o,  // locks to ref_clk_o
    output logic                              pll_b_clk_o,
    output logic                              pll_b_div8_o,  // locks to pll_a_div8_o
    output pll_cfg_pkg::pll_gain_t            gain_disp_o    // {kp, ki} for the display
);
    import pll_num_pkg::*;
    import pll_cfg_pkg::*;

    pll_cfg_t                     cfg_x;
    logic                         loop_en_x;        // switch 15
    logic signed [PDET_WIDTH-1:0] err_a_x;          // ref vs a
    logic signed [PDET_WIDTH-1:0] err_b_x;          // a vs b
    logic                         err_a_valid_x;
    logic                         err_b_valid_x;
    logic signed [PDET_WIDTH-1:0] err_a_term_c;     // zero when no strobe
    logic signed [PDET_WIDTH-1:0] err_b_term_c;
    logic signed [PDET_WIDTH:0]   err_diff_c;       // guard bit for the subtraction
    logic signed [PDET_WIDTH-1:0] err_a_cpl_c;      // coupled error into pll a
    logic                         err_a_cpl_valid_c;

    assign loop_en_x = switches_i[SW_ENABLE_BIT];

    pll_config_regs config_regs_i (
        .clk258_x   (clk258_x),
        .rst_n_i    (rst_n_i),
        .switches_i (switches_i),
        .cfg_o      (cfg_x)
    );

    phase_accum_osc ref_osc_i (
        .clk258_x   (clk258_x),
        .rst_n_i    (rst_n_i),
        .enable_i   (1'b1),
        .tune_i     (cfg_x.tune),
        .clk_o      (ref_clk_o)
    );

    phase_detector pdet_a_i (
        .clk258_x    (clk258_x),
        .rst_n_i     (rst_n_i),
        .ref_i       (ref_clk_o),
        .gen_i       (pll_a_div8_o),
        .err_o       (err_a_x),
        .err_valid_o (err_a_valid_x)
    );

    phase_detector pdet_b_i (
        .clk258_x    (clk258_x),
        .rst_n_i     (rst_n_i),
        .ref_i       (pll_a_div8_o),       // a is b's reference
        .gen_i       (pll_b_div8_o),
        .err_o       (err_b_x),
        .err_valid_o (err_b_valid_x)
    );

    // a is pulled back when it leads b, so both loops settle together
    assign err_a_term_c      = err_a_valid_x ? err_a_x : '0;
    assign err_b_term_c      = err_b_valid_x ? err_b_x : '0;
    assign err_diff_c        = err_a_term_c - err_b_term_c;
    assign err_a_cpl_c       = sat_err(err_diff_c);
    assign err_a_cpl_valid_c = err_a_valid_x | err_b_valid_x;

    adpll_core #(
        .BIAS_WORD   (BIAS)
    ) pll_a_i (
        .clk258_x    (clk258_x),
        .rst_n_i     (rst_n_i),
        .enable_i    (loop_en_x),
        .gain_i      (cfg_x.gain),
        .err_i       (err_a_cpl_c),
        .err_valid_i (err_a_cpl_valid_c),
        .gen_clk_o   (pll_a_clk_o),
        .gen_div8_o  (pll_a_div8_o)
    );

    adpll_core #(
        .BIAS_WORD   (BIAS - 1)            // one step slow when open loop
    ) pll_b_i (
        .clk258_x    (clk258_x),
        .rst_n_i     (rst_n_i),
        .enable_i    (loop_en_x),
        .gain_i      (cfg_x.gain),
        .err_i       (err_b_x),
        .err_valid_i (err_b_valid_x),
        .gen_clk_o   (pll_b_clk_o),
        .gen_div8_o  (pll_b_div8_o)
    );

    assign gain_disp_o = cfg_x.gain;

endmodule

//--- source/adpll_core.sv
module adpll_core #(
    parameter int BIAS_WORD = pll_num_pkg::BIAS        // free-running word
) (
    input  logic                                       clk258_x,
    input  logic                                       rst_n_i,
    input  logic                                       enable_i,     // loop closed when high
    input  pll_cfg_pkg::pll_gain_t                     gain_i,
    input  logic signed [pll_num_pkg::PDET_WIDTH-1:0]  err_i,        // from detector or coupling
    input  logic                                       err_valid_i,
    output logic                                       gen_clk_o,    // nco msb
    output logic                                       gen_div8_o    // gen_clk_o / 8
);
    import pll_num_pkg::*;

    logic [ACCUM_WIDTH-1:0] tune_x;        // filter to nco
    logic                   gen_d_r;       // previous nco sample
    logic                   gen_rise_c;
    logic [1:0]             edge_cnt_r;    // rising edges mod 4
    logic                   div8_r;

    pi_loop_filter #(
        .BIAS_WORD   (BIAS_WORD)
    ) loop_filter_i (
        .clk258_x    (clk258_x),
        .rst_n_i     (rst_n_i),
        .enable_i    (enable_i),
        .gain_i      (gain_i),
        .err_i       (err_i),
        .err_valid_i (err_valid_i),
        .tune_o      (tune_x)
    );

    phase_accum_osc dco_i (
        .clk258_x    (clk258_x),
        .rst_n_i     (rst_n_i),
        .enable_i    (1'b1),               // dco always runs, bias keeps it alive
        .tune_i      (tune_x),
        .clk_o       (gen_clk_o)
    );

    assign gen_rise_c = gen_clk_o & ~gen_d_r;

    // toggle every fourth rising edge, full period is eight nco cycles
    always_ff @(posedge clk258_x)
    begin
        if (!rst_n_i)
        begin
            gen_d_r    <= 1'b0;
            edge_cnt_r <= '0;
            div8_r     <= 1'b0;            // divided clock starts low
        end
        else
        begin
            gen_d_r <= gen_clk_o;
            if (gen_rise_c)
            begin
                edge_cnt_r <= edge_cnt_r + 2'd1;
                if (edge_cnt_r == 2'd3)
                    div8_r <= ~div8_r;     // fourth edge
            end
        end
    end

    assign gen_div8_o = div8_r;

endmodule

//--- source/pi_loop_filter.sv
module pi_loop_filter #(
    parameter int BIAS_WORD = pll_num_pkg::BIAS        // free-running word, 1..4095
) (
    input  logic                                       clk258_x,
    input  logic                                       rst_n_i,
    input  logic                                       enable_i,     // low: open loop
    input  pll_cfg_pkg::pll_gain_t                     gain_i,
    input  logic signed [pll_num_pkg::PDET_WIDTH-1:0]  err_i,
    input  logic                                       err_valid_i,
    output logic [pll_num_pkg::ACCUM_WIDTH-1:0]        tune_o        // nco word
);
    import pll_num_pkg::*;
    import pll_cfg_pkg::*;

    logic signed [KP_WIDTH-1:0]            kp_c;          // unsigned gain, sign bit zero
    logic signed [KI_WIDTH-1:0]            ki_c;
    logic signed [PDET_WIDTH+KP_WIDTH-1:0] p_prod_c;      // err * kp
    logic signed [PDET_WIDTH+KI_WIDTH-1:0] i_prod_c;      // err * ki
    logic signed [INTEG_WIDTH:0]           integ_sum_c;   // one guard bit
    logic signed [INTEG_WIDTH-1:0]         integ_next_c;
    logic signed [SUM_WIDTH-1:0]           word_sum_c;    // bias + p term + i term
    logic [ACCUM_WIDTH-1:0]                tune_next_c;
    logic signed [INTEG_WIDTH-1:0]         integ_r;
    logic [ACCUM_WIDTH-1:0]                tune_r;

    assign kp_c = $signed({{(KP_WIDTH-GAIN_WIDTH){1'b0}}, gain_i.kp});   // kp / 16
    assign ki_c = $signed({{(KI_WIDTH-GAIN_WIDTH){1'b0}}, gain_i.ki});   // ki / 256

    assign p_prod_c    = err_i * kp_c;
    assign i_prod_c    = err_i * ki_c;
    assign integ_sum_c = integ_r + i_prod_c;

    // integrator clips instead of wrapping
    always_comb
    begin
        if (integ_sum_c > INTEG_MAX)
            integ_next_c = INTEG_WIDTH'(INTEG_MAX);
        else if (integ_sum_c < INTEG_MIN)
            integ_next_c = INTEG_WIDTH'(INTEG_MIN);
        else
            integ_next_c = integ_sum_c[INTEG_WIDTH-1:0];
    end

    // fractions dropped by arithmetic shift, new integrator value feeds the word
    assign word_sum_c = SUM_WIDTH'(p_prod_c >>> KP_FRAC)
                      + SUM_WIDTH'(integ_next_c >>> KI_FRAC)
                      + SUM_WIDTH'(BIAS_WORD);

    // keep the nco running, never a zero word
    always_comb
    begin
        if (word_sum_c < TUNE_MIN)
            tune_next_c = ACCUM_WIDTH'(TUNE_MIN);
        else if (word_sum_c > TUNE_MAX)
            tune_next_c = ACCUM_WIDTH'(TUNE_MAX);
        else
            tune_next_c = word_sum_c[ACCUM_WIDTH-1:0];
    end

    // back-to-back strobes each see the previous integrator, none lost
    always_ff @(posedge clk258_x)
    begin
        if (!rst_n_i || !enable_i)
        begin
            integ_r <= '0;                          // correction zero
            tune_r  <= ACCUM_WIDTH'(BIAS_WORD);     // exactly the bias
        end
        else if (err_valid_i)
        begin
            integ_r <= integ_next_c;
            tune_r  <= tune_next_c;                 // one cycle after the strobe
        end
    end

    assign tune_o = tune_r;

endmodule

//--- source/phase_detector.sv
module phase_detector (
    input  logic                                       clk258_x,
    input  logic                                       rst_n_i,
    input  logic                                       ref_i,        // reference clock
    input  logic                                       gen_i,        // generated clock
    output logic signed [pll_num_pkg::PDET_WIDTH-1:0]  err_o,        // + means ref leads
    output logic                                       err_valid_o   // one-cycle strobe
);
    import pll_num_pkg::*;

    logic                         ref_d_r;       // previous ref sample
    logic                         gen_d_r;       // previous gen sample
    logic                         ref_rise_c;
    logic                         gen_rise_c;
    logic                         running_r;     // edge pair open
    logic                         up_r;          // ref opened the pair
    logic                         close_c;       // partner edge seen
    logic signed [1:0]            step_c;        // +1 or -1
    logic signed [PDET_WIDTH-1:0] cnt_r;         // cycles since opening edge
    logic signed [PDET_WIDTH:0]   cnt_step_c;    // next count before clipping
    logic signed [PDET_WIDTH-1:0] err_r;
    logic                         err_valid_r;

    assign ref_rise_c = ref_i & ~ref_d_r;
    assign gen_rise_c = gen_i & ~gen_d_r;
    assign close_c    = up_r ? gen_rise_c : ref_rise_c;   // only the other input closes
    assign step_c     = up_r ? 2'sb01 : 2'sb11;
    assign cnt_step_c = cnt_r + step_c;                   // sign extended to 9 bits

    always_ff @(posedge clk258_x)
    begin
        ref_d_r     <= ref_i;
        gen_d_r     <= gen_i;
        err_valid_r <= 1'b0;                              // strobe lasts one cycle
        if (!rst_n_i)
        begin
            ref_d_r   <= 1'b0;
            gen_d_r   <= 1'b0;
            running_r <= 1'b0;
        end
        else if (!running_r)
        begin
            if (ref_rise_c && gen_rise_c)
            begin
                err_r       <= '0;                        // aligned edges
                err_valid_r <= 1'b1;
            end
            else if (ref_rise_c || gen_rise_c)
            begin
                running_r <= 1'b1;
                up_r      <= ref_rise_c;                  // ref first counts up
                cnt_r     <= ref_rise_c ? PDET_WIDTH'(1) : PDET_WIDTH'(-1);
            end
        end
        else if (close_c)
        begin
            err_r       <= cnt_r;                         // result one cycle after close
            err_valid_r <= 1'b1;
            running_r   <= 1'b0;
        end
        else
        begin
            cnt_r <= sat_err(cnt_step_c);                 // sticks at +/- ERR_MAX
        end
    end

    // repeated edges of the opening input are ignored until the pair closes
    assign err_o       = err_r;
    assign err_valid_o = err_valid_r;

endmodule

//--- source/phase_accum_osc.sv
module phase_accum_osc (
    input  logic                                 clk258_x,
    input  logic                                 rst_n_i,
    input  logic                                 enable_i,  // hold phase when low
    input  logic [pll_num_pkg::ACCUM_WIDTH-1:0]  tune_i,    // phase step per cycle
    output logic                                 clk_o      // accumulator msb
);
    import pll_num_pkg::*;

    // f_out = tune_i * f_clk258 / 2**ACCUM_WIDTH
    logic [ACCUM_WIDTH-1:0] accum_r;    // phase, wraps naturally

    always_ff @(posedge clk258_x)
    begin
        if (!rst_n_i)
        begin
            accum_r <= '0;                       // phase zero, clock low
        end
        else if (enable_i)
        begin
            accum_r <= accum_r + tune_i;         // modulo 4096 by width
        end
    end

    // msb is already a flop output, so clk_o is glitch free
    assign clk_o = accum_r[ACCUM_WIDTH-1];

endmodule

//--- source/pll_config_regs.sv
module pll_config_regs (
    input  logic                              clk258_x,
    input  logic                              rst_n_i,
    input  logic [pll_cfg_pkg::SW_WIDTH-1:0]  switches_i,   // load level on bit 12
    output pll_cfg_pkg::pll_cfg_t             cfg_o         // gains plus reference word
);
    import pll_cfg_pkg::*;

    pll_cfg_t cfg_r;        // captured configuration
    logic     load_c;       // switch load level

    assign load_c = switches_i[SW_LOAD_BIT];

    // load high: tuning word follows the switches, gains frozen
    // load low: gains follow the switches, reference frequency untouched
    always_ff @(posedge clk258_x)
    begin
        if (!rst_n_i)
        begin
            cfg_r <= CFG_RESET;                                    // word 19, kp 8, ki 9
        end
        else if (load_c)
        begin
            cfg_r.tune <= switches_i[TUNE_WIDTH-1:0];              // bits 11..0
        end
        else
        begin
            cfg_r.gain.kp <= switches_i[KP_SW_LSB +: GAIN_WIDTH];  // bits 11..8
            cfg_r.gain.ki <= switches_i[KI_SW_LSB +: GAIN_WIDTH];  // bits 3..0
        end
    end

    assign cfg_o = cfg_r;   // one cycle behind the switches

endmodule

//--- source/pll_cfg_pkg.sv
package pll_cfg_pkg;

    localparam int GAIN_WIDTH    = 4;      // raw kp and ki fields
    localparam int TUNE_WIDTH    = 12;     // reference tuning word
    localparam int SW_WIDTH      = 16;     // switch word
    localparam int SW_LOAD_BIT   = 12;     // high: capture tuning word
    localparam int SW_ENABLE_BIT = 15;     // loop enable level
    localparam int KP_SW_LSB     = 8;      // kp sits in switches 11..8
    localparam int KI_SW_LSB     = 0;      // ki sits in switches 3..0

    localparam logic [GAIN_WIDTH-1:0] KP_RESET   = 4'd8;    // loop gains out of reset
    localparam logic [GAIN_WIDTH-1:0] KI_RESET   = 4'd9;
    localparam logic [TUNE_WIDTH-1:0] TUNE_RESET = 12'd19;  // reference word out of reset

    typedef struct packed {
        logic [GAIN_WIDTH-1:0] kp;         // upper nibble of the display value
        logic [GAIN_WIDTH-1:0] ki;         // lower nibble
    } pll_gain_t;

    typedef struct packed {
        pll_gain_t             gain;       // shared by both loop filters
        logic [TUNE_WIDTH-1:0] tune;       // reference nco word
    } pll_cfg_t;

    localparam pll_cfg_t CFG_RESET = '{gain: '{kp: KP_RESET, ki: KI_RESET}, tune: TUNE_RESET};

endpackage

//--- source/pll_num_pkg.sv
package pll_num_pkg;

    localparam int ACCUM_WIDTH = 12;       // nco accumulator, shared by all oscillators
    localparam int PDET_WIDTH  = 8;        // signed phase error
    localparam int BIAS        = 154;      // free-running word of pll a
    localparam int KP_WIDTH    = 5;        // kp after zero extension
    localparam int KP_FRAC     = 4;        // kp fraction bits
    localparam int KI_WIDTH    = 9;        // ki after zero extension
    localparam int KI_FRAC     = 8;        // ki fraction bits
    localparam int INTEG_WIDTH = 20;       // integrator register
    localparam int ERR_MAX     = 127;      // phase error clip level

    localparam int INTEG_MAX = 2**(INTEG_WIDTH-1) - 1;    // integrator clip, positive side
    localparam int INTEG_MIN = -(2**(INTEG_WIDTH-1));     // integrator clip, negative side
    localparam int SUM_WIDTH = INTEG_WIDTH + 2;           // headroom for bias plus correction
    localparam int TUNE_MIN  = 1;                         // zero word would stall the nco
    localparam int TUNE_MAX  = 2**ACCUM_WIDTH - 1;        // largest word the nco accepts

    // clip a one-bit-wider signed value to +/- ERR_MAX
    function automatic logic signed [PDET_WIDTH-1:0] sat_err(
        input logic signed [PDET_WIDTH:0] val
    );
        logic signed [PDET_WIDTH-1:0] res;
        if (val > ERR_MAX)
            res = PDET_WIDTH'(ERR_MAX);                   // clip high
        else if (val < -ERR_MAX)
            res = PDET_WIDTH'(-ERR_MAX);                  // clip low, symmetric
        else
            res = val[PDET_WIDTH-1:0];                    // in range, drop the extra bit
        return res;
    endfunction

endpackage
